//--- include/soc_cfg.svh
// soc harness configuration: bus widths, address map, memory sizes and interrupt positions
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// ------------------------------------------------
// bus widths
// ------------------------------------------------
`define SOC_ADDR_W 32
// also the XLEN of the interrupt vector
`define SOC_DATA_W 64

// ------------------------------------------------
// address map
// ------------------------------------------------
`define SOC_ROM_BASE   32'h0001_0000
`define SOC_ROM_WORDS  16
`define SOC_CLINT_BASE 32'h0200_0000
`define SOC_CLINT_SIZE 32'h0001_0000
`define SOC_RAM_BASE   32'h8000_0000
`define SOC_RAM_WORDS  1024

// clint register offsets, low 16 address bits
`define SOC_CLINT_MSIP_OFS     16'h0000
`define SOC_CLINT_MTIMECMP_OFS 16'h4000
`define SOC_CLINT_MTIME_OFS    16'hBFF8

// ------------------------------------------------
// debug and interrupts
// ------------------------------------------------
// cycles after power-on before a debug request reaches the core
`define SOC_DEBUG_HOLD_CYCLES 20

// machine interrupt-pending bit positions
`define SOC_IRQ_MSIP_BIT 3
`define SOC_IRQ_MTIP_BIT 7
`define SOC_IRQ_SEIP_BIT 9
`define SOC_IRQ_MEIP_BIT 11

`endif

//--- design/soc_pkg.sv
// soc harness shared types for the bus, the interrupt vector and the debug window
package soc_pkg;

  // byte address on the harness bus
  typedef logic [31:0] addr_t;

  // bus data word, also the width of the clint registers
  typedef logic [63:0] data_t;

  // one enable per data byte
  typedef logic [7:0] be_t;

  // one-hot target select
  // bit 0 rom, bit 1 clint, bit 2 sram
  typedef logic [2:0] slave_sel_t;

  // machine interrupt-pending vector, xlen wide
  typedef logic [63:0] irq_vec_t;

  // debug request window after power-on
  typedef enum logic {
    DBG_HOLD,
    DBG_OPEN
  } dbg_state_e;

endpackage

//--- design/soc_debug_ctrl.sv
// debug control: system reset synchronizer and post power-on debug request gate
`timescale 1ns/1ns
`include "soc_cfg.svh"

module soc_debug_ctrl import soc_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  input  logic debug_req_i,
  input  logic debug_enable_i,
  output logic sys_rst_no,
  output logic debug_req_o
);

  localparam int unsigned CNT_W = $clog2(`SOC_DEBUG_HOLD_CYCLES + 1);

  logic             rst_comb_n;
  logic [1:0]       rst_sync_q;
  logic [CNT_W-1:0] hold_cnt_q;
  dbg_state_e       state_q;

  // ------------------------------------------------
  // system reset
  // ------------------------------------------------
  // either source asserts at once and release waits two edges
  assign rst_comb_n = rst_ni & ~ndmreset_i;

  always_ff @(posedge clk_i or negedge rst_comb_n) begin
    if (!rst_comb_n) begin
      rst_sync_q <= 2'b00;
    end else begin
      rst_sync_q <= {rst_sync_q[0], 1'b1};
    end
  end

  assign sys_rst_no = rst_sync_q[1];

  // ------------------------------------------------
  // debug hold window
  // ------------------------------------------------
  // ndmreset leaves the hold window alone
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= DBG_HOLD;
      hold_cnt_q <= CNT_W'(`SOC_DEBUG_HOLD_CYCLES);
    end else if (state_q == DBG_HOLD) begin
      if (hold_cnt_q == CNT_W'(1)) begin
        state_q <= DBG_OPEN;
      end
      hold_cnt_q <= hold_cnt_q - 1'b1;
    end
  end

  // boot code runs undisturbed until the window opens
  assign debug_req_o = (state_q == DBG_OPEN) & debug_req_i & debug_enable_i;

  // no debug request while the hold count runs
  a_no_debug_in_hold : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (hold_cnt_q != '0) |-> !debug_req_o
  );

endmodule

//--- design/soc_bus_demux.sv
// bus demux: address decode, target request steering, response select and decode error
`timescale 1ns/1ns
`include "soc_cfg.svh"

module soc_bus_demux import soc_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  req_i,
  input  logic  we_i,
  input  addr_t addr_i,
  input  be_t   be_i,
  input  data_t wdata_i,
  output logic  rom_req_o,
  output logic  clint_req_o,
  output logic  ram_req_o,
  input  data_t rom_rdata_i,
  input  data_t clint_rdata_i,
  input  data_t ram_rdata_i,
  output logic  rvalid_o,
  output logic  err_o,
  output data_t rdata_o
);

  // exclusive window ends
  localparam logic [`SOC_ADDR_W-1:0] ROM_END =
    `SOC_ROM_BASE + `SOC_ROM_WORDS * (`SOC_DATA_W / 8);
  localparam logic [`SOC_ADDR_W-1:0] CLINT_END = `SOC_CLINT_BASE + `SOC_CLINT_SIZE;
  localparam logic [`SOC_ADDR_W-1:0] RAM_END =
    `SOC_RAM_BASE + `SOC_RAM_WORDS * (`SOC_DATA_W / 8);

  slave_sel_t sel_d;
  slave_sel_t sel_q;
  logic       valid_q;
  logic       err_q;
  logic       we_q;

  // ------------------------------------------------
  // decode and request steering
  // ------------------------------------------------
  assign sel_d[0] = (addr_i >= addr_t'(`SOC_ROM_BASE)) && (addr_i < ROM_END);
  assign sel_d[1] = (addr_i >= addr_t'(`SOC_CLINT_BASE)) && (addr_i < CLINT_END);
  assign sel_d[2] = (addr_i >= addr_t'(`SOC_RAM_BASE)) && (addr_i < RAM_END);

  assign rom_req_o   = req_i & sel_d[0];
  assign clint_req_o = req_i & sel_d[1];
  assign ram_req_o   = req_i & sel_d[2];

  // ------------------------------------------------
  // response cycle
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      err_q   <= 1'b0;
      we_q    <= 1'b0;
      sel_q   <= '0;
    end else begin
      valid_q <= req_i;
      err_q   <= req_i & (sel_d == '0);
      we_q    <= we_i;
      sel_q   <= req_i ? sel_d : '0;
    end
  end

  // unmapped and idle cycles fall to zero
  always_comb begin
    rdata_o = '0;
    if (!we_q) begin
      case (sel_q)
        3'b001:  rdata_o = rom_rdata_i;
        3'b010:  rdata_o = clint_rdata_i;
        3'b100:  rdata_o = ram_rdata_i;
        default: rdata_o = '0;
      endcase
    end
  end

  assign rvalid_o = valid_q;
  assign err_o    = err_q;

  // windows must not overlap
  a_sel_onehot : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    rvalid_o |-> $onehot0(sel_q)
  );

  a_write_known : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (req_i && we_i) |-> !$isunknown({be_i, wdata_i})
  );

endmodule

//--- design/soc_bootrom.sv
// boot rom: read-only word memory preloaded from the boot image
`timescale 1ns/1ns
`include "soc_cfg.svh"

module soc_bootrom import soc_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  req_i,
  input  logic  we_i,
  input  addr_t addr_i,
  output data_t rdata_o
);

  localparam int unsigned OFS_W = $clog2(`SOC_DATA_W / 8);
  localparam int unsigned IDX_W = $clog2(`SOC_ROM_WORDS);

  data_t mem [`SOC_ROM_WORDS];

  initial begin
    $readmemh("bootrom.hex", mem);
  end

  // writes are dropped and answer zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (req_i) begin
      rdata_o <= we_i ? '0 : mem[addr_i[OFS_W +: IDX_W]];
    end
  end

endmodule

//--- design/soc_sram.sv
// main sram: byte-enabled word memory with a registered one-cycle read
`timescale 1ns/1ns
`include "soc_cfg.svh"

module soc_sram import soc_pkg::*; #(
  parameter int unsigned NUM_WORDS = `SOC_RAM_WORDS
) (
  input  logic  clk_i,
  input  logic  req_i,
  input  logic  we_i,
  input  addr_t addr_i,
  input  be_t   be_i,
  input  data_t wdata_i,
  output data_t rdata_o
);

  localparam int unsigned OFS_W = $clog2($bits(be_t));
  localparam int unsigned IDX_W = $clog2(NUM_WORDS);

  data_t            mem [NUM_WORDS];
  logic [IDX_W-1:0] idx;

  // address wraps modulo the array size
  assign idx = addr_i[OFS_W +: IDX_W];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < $bits(be_t); b++) begin
          if (be_i[b]) begin
            mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem[idx];
      end
    end
  end

  a_addr_known : assert property (
    @(posedge clk_i) req_i |-> !$isunknown(addr_i)
  );

endmodule

//--- design/soc_clint.sv
// clint: mtime, mtimecmp and msip registers driving the timer and software interrupts
`timescale 1ns/1ns
`include "soc_cfg.svh"

module soc_clint import soc_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  rtc_i,
  input  logic  req_i,
  input  logic  we_i,
  input  addr_t addr_i,
  input  be_t   be_i,
  input  data_t wdata_i,
  output data_t rdata_o,
  output logic  timer_irq_o,
  output logic  ipi_o
);

  // two sync stages plus one history bit
  logic [2:0]  rtc_q;
  logic        rtc_rise;
  logic        msip_q;
  data_t       mtimecmp_q;
  data_t       mtime_q;
  logic [15:0] ofs;
  logic        wr_msip;
  logic        wr_cmp;
  logic        wr_time;
  data_t       rd_val;

  function automatic data_t apply_be(data_t old_val, data_t new_val, be_t be);
    data_t res;
    res = old_val;
    for (int b = 0; b < $bits(be_t); b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

  // ------------------------------------------------
  // rtc edge detect
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rtc_q <= '0;
    end else begin
      rtc_q <= {rtc_q[1:0], rtc_i};
    end
  end

  assign rtc_rise = rtc_q[1] & ~rtc_q[2];

  // ------------------------------------------------
  // registers
  // ------------------------------------------------
  assign ofs     = addr_i[15:0];
  assign wr_msip = req_i && we_i && (ofs == `SOC_CLINT_MSIP_OFS);
  assign wr_cmp  = req_i && we_i && (ofs == `SOC_CLINT_MTIMECMP_OFS);
  assign wr_time = req_i && we_i && (ofs == `SOC_CLINT_MTIME_OFS);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      msip_q     <= 1'b0;
      mtimecmp_q <= '1;
      mtime_q    <= '0;
    end else begin
      if (wr_msip && be_i[0]) begin
        msip_q <= wdata_i[0];
      end
      if (wr_cmp) begin
        mtimecmp_q <= apply_be(mtimecmp_q, wdata_i, be_i);
      end
      // software write beats the tick
      if (wr_time) begin
        mtime_q <= apply_be(mtime_q, wdata_i, be_i);
      end else if (rtc_rise) begin
        mtime_q <= mtime_q + 1'b1;
      end
    end
  end

  // ------------------------------------------------
  // read path
  // ------------------------------------------------
  always_comb begin
    case (ofs)
      `SOC_CLINT_MSIP_OFS:     rd_val = data_t'(msip_q);
      `SOC_CLINT_MTIMECMP_OFS: rd_val = mtimecmp_q;
      `SOC_CLINT_MTIME_OFS:    rd_val = mtime_q;
      default:                 rd_val = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (req_i) begin
      rdata_o <= we_i ? '0 : rd_val;
    end
  end

  assign timer_irq_o = (mtime_q >= mtimecmp_q);
  assign ipi_o       = msip_q;

  // reset value of mtimecmp keeps the timer quiet
  a_cmp_idle_quiet : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (mtimecmp_q == '1) |-> !timer_irq_o
  );

endmodule

//--- design/soc_harness_top.sv
// soc harness top: reset and debug control, bus demux, memories, clint and interrupt packing
`timescale 1ns/1ns
`include "soc_cfg.svh"

module soc_harness_top import soc_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       rtc_i,
  input  logic       ndmreset_i,
  input  logic       debug_req_i,
  input  logic       debug_enable_i,
  input  logic       req_i,
  input  logic       we_i,
  input  logic [1:0] irq_i,
  input  addr_t      addr_i,
  input  be_t        be_i,
  input  data_t      wdata_i,
  output logic       rvalid_o,
  output logic       err_o,
  output data_t      rdata_o,
  output logic       debug_req_o,
  output irq_vec_t   irq_vec_o
);

  logic  sys_rst_n;
  logic  rom_req;
  logic  clint_req;
  logic  ram_req;
  data_t rom_rdata;
  data_t clint_rdata;
  data_t ram_rdata;
  logic  timer_irq;
  logic  ipi;

  // ------------------------------------------------
  // reset and debug
  // ------------------------------------------------
  soc_debug_ctrl i_soc_debug_ctrl (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .ndmreset_i     ( ndmreset_i     ),
    .debug_req_i    ( debug_req_i    ),
    .debug_enable_i ( debug_enable_i ),
    .sys_rst_no     ( sys_rst_n      ),
    .debug_req_o    ( debug_req_o    )
  );

  // ------------------------------------------------
  // bus and targets
  // ------------------------------------------------
  soc_bus_demux i_soc_bus_demux (
    .clk_i         ( clk_i       ),
    .rst_ni        ( sys_rst_n   ),
    .req_i         ( req_i       ),
    .we_i          ( we_i        ),
    .addr_i        ( addr_i      ),
    .be_i          ( be_i        ),
    .wdata_i       ( wdata_i     ),
    .rom_req_o     ( rom_req     ),
    .clint_req_o   ( clint_req   ),
    .ram_req_o     ( ram_req     ),
    .rom_rdata_i   ( rom_rdata   ),
    .clint_rdata_i ( clint_rdata ),
    .ram_rdata_i   ( ram_rdata   ),
    .rvalid_o      ( rvalid_o    ),
    .err_o         ( err_o       ),
    .rdata_o       ( rdata_o     )
  );

  soc_bootrom i_soc_bootrom (
    .clk_i   ( clk_i     ),
    .rst_ni  ( sys_rst_n ),
    .req_i   ( rom_req   ),
    .we_i    ( we_i      ),
    .addr_i  ( addr_i    ),
    .rdata_o ( rom_rdata )
  );

  // sram contents survive ndmreset
  soc_sram #(
    .NUM_WORDS ( `SOC_RAM_WORDS )
  ) i_soc_sram (
    .clk_i   ( clk_i     ),
    .req_i   ( ram_req   ),
    .we_i    ( we_i      ),
    .addr_i  ( addr_i    ),
    .be_i    ( be_i      ),
    .wdata_i ( wdata_i   ),
    .rdata_o ( ram_rdata )
  );

  soc_clint i_soc_clint (
    .clk_i       ( clk_i       ),
    .rst_ni      ( sys_rst_n   ),
    .rtc_i       ( rtc_i       ),
    .req_i       ( clint_req   ),
    .we_i        ( we_i        ),
    .addr_i      ( addr_i      ),
    .be_i        ( be_i        ),
    .wdata_i     ( wdata_i     ),
    .rdata_o     ( clint_rdata ),
    .timer_irq_o ( timer_irq   ),
    .ipi_o       ( ipi         )
  );

  // ------------------------------------------------
  // interrupt vector
  // ------------------------------------------------
  // irq_i bit 0 is meip, bit 1 is seip
  always_comb begin
    irq_vec_o                    = '0;
    irq_vec_o[`SOC_IRQ_MSIP_BIT] = ipi;
    irq_vec_o[`SOC_IRQ_MTIP_BIT] = timer_irq;
    irq_vec_o[`SOC_IRQ_SEIP_BIT] = irq_i[1];
    irq_vec_o[`SOC_IRQ_MEIP_BIT] = irq_i[0];
  end

endmodule

//--- testbench/tb_soc_harness.sv
// soc harness testbench: directed tests of debug gating, bus map, memories and clint
`timescale 1ns/1ns
`include "soc_cfg.svh"

module tb_soc_harness import soc_pkg::*; ();

  // far more than the tests take
  localparam int unsigned TIMEOUT_CYCLES = 6000;
  localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;

  logic       clk_i = 1'b0;
  logic       rtc_i = 1'b0;
  logic       rst_ni;
  logic       ndmreset_i;
  logic       debug_req_i;
  logic       debug_enable_i;
  logic       req_i;
  logic       we_i;
  logic [1:0] irq_i;
  addr_t      addr_i;
  be_t        be_i;
  data_t      wdata_i;
  logic       rvalid_o;
  logic       err_o;
  data_t      rdata_o;
  logic       debug_req_o;
  irq_vec_t   irq_vec_o;

  int unsigned error_cnt;
  int unsigned test_cnt;
  int unsigned cycle_cnt;
  logic [31:0] lfsr_q;
  data_t       rom_img [`SOC_ROM_WORDS];
  data_t       ram_model [`SOC_RAM_WORDS];
  logic [9:0]  ram_idx [16];

  soc_harness_top i_soc_harness_top (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .rtc_i          ( rtc_i          ),
    .ndmreset_i     ( ndmreset_i     ),
    .debug_req_i    ( debug_req_i    ),
    .debug_enable_i ( debug_enable_i ),
    .req_i          ( req_i          ),
    .we_i           ( we_i           ),
    .irq_i          ( irq_i          ),
    .addr_i         ( addr_i         ),
    .be_i           ( be_i           ),
    .wdata_i        ( wdata_i        ),
    .rvalid_o       ( rvalid_o       ),
    .err_o          ( err_o          ),
    .rdata_o        ( rdata_o        ),
    .debug_req_o    ( debug_req_o    ),
    .irq_vec_o      ( irq_vec_o      )
  );

  always #2 clk_i = ~clk_i;

  // slow real-time clock of 16 clk_i cycles per period
  always begin
    repeat (8) @(negedge clk_i);
    rtc_i = ~rtc_i;
  end

  // ------------------------------------------------
  // helpers
  // ------------------------------------------------
  // galois lfsr stepped once per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] res;
    logic        lsb;
    res = '0;
    for (int i = 0; i < n; i++) begin
      lsb    = lfsr_q[0];
      lfsr_q = lfsr_q >> 1;
      if (lsb) begin
        lfsr_q = lfsr_q ^ LFSR_TAPS;
      end
      res = {res[62:0], lsb};
    end
    return res;
  endfunction

  function automatic addr_t ram_addr(input logic [9:0] idx);
    return addr_t'(`SOC_RAM_BASE) + {idx, 3'b000};
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("FAIL %s: expected %0h, actual %0h", name, exp, act);
    error_cnt++;
  endtask

  task automatic report_problem(input string what);
    $display("ERROR %s", what);
    error_cnt++;
  endtask

  // the response to this request is visible on return
  task automatic drive_req(input logic we, input addr_t addr, input be_t be,
                           input data_t wdata);
    req_i   = 1'b1;
    we_i    = we;
    addr_i  = addr;
    be_i    = be;
    wdata_i = wdata;
    @(negedge clk_i);
  endtask

  task automatic drive_idle();
    req_i   = 1'b0;
    we_i    = 1'b0;
    addr_i  = '0;
    be_i    = '0;
    wdata_i = '0;
    @(negedge clk_i);
  endtask

  task automatic expect_resp(input string name, input logic exp_err, input data_t exp_data);
    if (rvalid_o !== 1'b1) begin
      report_problem({name, ": no rvalid_o one cycle after the request"});
    end else begin
      if (err_o !== exp_err) begin
        report_mismatch({name, " err"}, exp_err, err_o);
      end
      if (rdata_o !== exp_data) begin
        report_mismatch({name, " rdata"}, exp_data, rdata_o);
      end
    end
  endtask

  task automatic expect_quiet(input string name);
    if (rvalid_o !== 1'b0 || err_o !== 1'b0) begin
      report_problem({name, ": response seen without a request"});
    end
  endtask

  task automatic expect_vec(input string name, input irq_vec_t exp);
    if (irq_vec_o !== exp) begin
      report_mismatch(name, exp, irq_vec_o);
    end
  endtask

  // ------------------------------------------------
  // tests
  // ------------------------------------------------
  task automatic check_debug_hold();
    test_cnt++;
    rst_ni = 1'b1;
    for (int i = 0; i < `SOC_DEBUG_HOLD_CYCLES; i++) begin
      if (debug_req_o !== 1'b0) begin
        report_problem($sformatf("debug hold: debug_req_o high %0d cycles after reset", i));
      end
      @(negedge clk_i);
    end
    if (debug_req_o !== 1'b1) begin
      report_mismatch("debug hold open", 1, debug_req_o);
    end
    debug_enable_i = 1'b0;
    @(negedge clk_i);
    if (debug_req_o !== 1'b0) begin
      report_mismatch("debug enable off", 0, debug_req_o);
    end
    debug_enable_i = 1'b1;
    @(negedge clk_i);
    if (debug_req_o !== 1'b1) begin
      report_mismatch("debug enable on", 1, debug_req_o);
    end
  endtask

  task automatic sram_walk();
    data_t      wr_data;
    be_t        wr_be;
    logic [9:0] idx;
    test_cnt++;
    // full words first so every byte of the model is known
    for (int i = 0; i < 16; i++) begin
      ram_idx[i] = 10'(rand_bits(10));
      wr_data    = rand_bits(64);
      drive_req(1'b1, ram_addr(ram_idx[i]), 8'hff, wr_data);
      expect_resp("sram fill write", 1'b0, '0);
      ram_model[ram_idx[i]] = wr_data;
    end
    for (int i = 0; i < 16; i++) begin
      idx     = ram_idx[i];
      wr_be   = be_t'(rand_bits(8));
      wr_data = rand_bits(64);
      drive_req(1'b1, ram_addr(idx), wr_be, wr_data);
      expect_resp("sram byte write", 1'b0, '0);
      for (int b = 0; b < 8; b++) begin
        if (wr_be[b]) begin
          ram_model[idx][8*b +: 8] = wr_data[8*b +: 8];
        end
      end
    end
    for (int i = 0; i < 16; i++) begin
      drive_req(1'b0, ram_addr(ram_idx[i]), 8'hff, '0);
      expect_resp($sformatf("sram read %0d", i), 1'b0, ram_model[ram_idx[i]]);
    end
    drive_idle();
    expect_quiet("sram idle");
  endtask

  task automatic bootrom_readback();
    test_cnt++;
    for (int i = 0; i < `SOC_ROM_WORDS; i++) begin
      drive_req(1'b0, addr_t'(`SOC_ROM_BASE + i * 8), 8'hff, '0);
      expect_resp($sformatf("rom word %0d", i), 1'b0, rom_img[i]);
    end
    drive_req(1'b1, addr_t'(`SOC_ROM_BASE + 5 * 8), 8'hff, rand_bits(64));
    expect_resp("rom write", 1'b0, '0);
    drive_req(1'b0, addr_t'(`SOC_ROM_BASE + 5 * 8), 8'hff, '0);
    expect_resp("rom word 5 after write", 1'b0, rom_img[5]);
    drive_idle();
    expect_quiet("rom idle");
  endtask

  task automatic unmapped_access();
    addr_t bad [5];
    test_cnt++;
    // just past each window and at both ends of the address space
    bad[0] = 32'h0000_0000;
    bad[1] = `SOC_ROM_BASE + `SOC_ROM_WORDS * 8;
    bad[2] = `SOC_CLINT_BASE + `SOC_CLINT_SIZE;
    bad[3] = `SOC_RAM_BASE + `SOC_RAM_WORDS * 8;
    bad[4] = 32'hffff_fff8;
    for (int i = 0; i < 5; i++) begin
      drive_req(1'b0, bad[i], 8'hff, '0);
      expect_resp($sformatf("unmapped read %h", bad[i]), 1'b1, '0);
      drive_req(1'b1, bad[i], 8'hff, rand_bits(64));
      expect_resp($sformatf("unmapped write %h", bad[i]), 1'b1, '0);
    end
    drive_idle();
    expect_quiet("unmapped idle");
  endtask

  task automatic clint_interrupts();
    irq_vec_t exp_vec;
    test_cnt++;
    exp_vec = '0;
    expect_vec("irq vector idle", exp_vec);
    drive_req(1'b1, `SOC_CLINT_BASE + `SOC_CLINT_MSIP_OFS, 8'hff, 64'd1);
    expect_resp("msip write", 1'b0, '0);
    exp_vec[`SOC_IRQ_MSIP_BIT] = 1'b1;
    expect_vec("msip irq", exp_vec);
    irq_i = 2'b11;
    drive_idle();
    exp_vec[`SOC_IRQ_MEIP_BIT] = 1'b1;
    exp_vec[`SOC_IRQ_SEIP_BIT] = 1'b1;
    expect_vec("external irq", exp_vec);
    drive_req(1'b1, `SOC_CLINT_BASE + `SOC_CLINT_MTIME_OFS, 8'hff, 64'd100);
    expect_resp("mtime write", 1'b0, '0);
    drive_req(1'b1, `SOC_CLINT_BASE + `SOC_CLINT_MTIMECMP_OFS, 8'hff, 64'd105);
    expect_resp("mtimecmp write", 1'b0, '0);
    drive_idle();
    expect_vec("timer not yet due", exp_vec);
    // six edges leave margin for one lost to the mtime write
    repeat (6) @(posedge rtc_i);
    repeat (4) @(negedge clk_i);
    exp_vec[`SOC_IRQ_MTIP_BIT] = 1'b1;
    expect_vec("timer irq", exp_vec);
    drive_req(1'b0, `SOC_CLINT_BASE + `SOC_CLINT_MTIME_OFS, 8'hff, '0);
    if (rvalid_o !== 1'b1 || err_o !== 1'b0) begin
      report_problem("mtime read: no clean response");
    end else if ($isunknown(rdata_o) || rdata_o < 64'd105) begin
      report_mismatch("mtime read at least", 64'd105, rdata_o);
    end
    drive_req(1'b0, `SOC_CLINT_BASE + `SOC_CLINT_MTIMECMP_OFS, 8'hff, '0);
    expect_resp("mtimecmp read", 1'b0, 64'd105);
    drive_req(1'b0, `SOC_CLINT_BASE + `SOC_CLINT_MSIP_OFS, 8'hff, '0);
    expect_resp("msip read", 1'b0, 64'd1);
    irq_i = 2'b00;
    drive_idle();
    exp_vec[`SOC_IRQ_MEIP_BIT] = 1'b0;
    exp_vec[`SOC_IRQ_SEIP_BIT] = 1'b0;
    expect_vec("external irq cleared", exp_vec);
  endtask

  task automatic debug_reset_pulse();
    test_cnt++;
    ndmreset_i = 1'b1;
    repeat (2) @(negedge clk_i);
    expect_quiet("bus in ndmreset");
    expect_vec("irq vector in ndmreset", '0);
    if (debug_req_o !== 1'b1) begin
      report_mismatch("debug open in ndmreset", 1, debug_req_o);
    end
    ndmreset_i = 1'b0;
    repeat (3) @(negedge clk_i);
    drive_req(1'b0, `SOC_CLINT_BASE + `SOC_CLINT_MSIP_OFS, 8'hff, '0);
    expect_resp("msip after ndmreset", 1'b0, '0);
    drive_req(1'b0, `SOC_CLINT_BASE + `SOC_CLINT_MTIMECMP_OFS, 8'hff, '0);
    expect_resp("mtimecmp after ndmreset", 1'b0, '1);
    // at most a synchronizer glitch and one real tick since release
    drive_req(1'b0, `SOC_CLINT_BASE + `SOC_CLINT_MTIME_OFS, 8'hff, '0);
    if (rvalid_o !== 1'b1 || $isunknown(rdata_o) || rdata_o > 64'd2) begin
      report_mismatch("mtime after ndmreset at most", 64'd2, rdata_o);
    end
    for (int i = 0; i < 16; i++) begin
      drive_req(1'b0, ram_addr(ram_idx[i]), 8'hff, '0);
      expect_resp($sformatf("sram %0d after ndmreset", i), 1'b0, ram_model[ram_idx[i]]);
    end
    drive_idle();
    if (debug_req_o !== 1'b1) begin
      report_mismatch("debug open after ndmreset", 1, debug_req_o);
    end
  endtask

  // ------------------------------------------------
  // main sequence
  // ------------------------------------------------
  initial begin
    error_cnt      = 0;
    test_cnt       = 0;
    lfsr_q         = 32'h1bcd;
    rst_ni         = 1'b0;
    ndmreset_i     = 1'b0;
    debug_req_i    = 1'b1;
    debug_enable_i = 1'b1;
    req_i          = 1'b0;
    we_i           = 1'b0;
    irq_i          = 2'b00;
    addr_i         = '0;
    be_i           = '0;
    wdata_i        = '0;
    $readmemh("bootrom.hex", rom_img);
    repeat (8) @(negedge clk_i);
    if (rvalid_o !== 1'b0 || err_o !== 1'b0 || debug_req_o !== 1'b0) begin
      report_problem("outputs not low during power-on reset");
    end
    check_debug_hold();
    sram_walk();
    bootrom_readback();
    unmapped_access();
    clint_interrupts();
    debug_reset_pulse();
    $display("%0d tests run, %0d errors", test_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles, the tests did not finish", cycle_cnt);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+include
design/soc_pkg.sv
design/soc_debug_ctrl.sv
design/soc_bus_demux.sv
design/soc_bootrom.sv
design/soc_sram.sv
design/soc_clint.sv
design/soc_harness_top.sv
testbench/tb_soc_harness.sv

//--- bootrom.hex
// one 64-bit boot word per line, word 0 first
00000297_02028593
f1402573_0182b283
00028067_00000013
10500073_ffdff06f
80000537_00050067
0000000f_0ff0000f
30047073_34202573
deadbeef_cafef00d
0123_4567_89ab_cdef
fedc_ba98_7654_3210
a5a5a5a5_5a5a5a5a
13579bdf_2468ace0
00010000_80000000
02000000_0200bff8
7ffff000_00001000
c0ffee00_0badf00d
